// ==== src/ps2_pkg.sv ====
`default_nettype none

package ps2_pkg;

	// One scan code as carried by a device-to-host frame
	localparam int SCAN_CODE_BITS = 8;

	typedef logic [SCAN_CODE_BITS-1:0] scan_code_t;

	// Data bits between start bit and parity bit
	localparam int FRAME_DATA_BITS = 8;

	// Both lines are pulled up when the bus is at rest
	localparam logic LINE_IDLE = 1'b1;

	// Frame layout, for reference
	//   bit 0      start, always low
	//   bits 1..8  data, LSB first
	//   bit 9      odd parity over the data
	//   bit 10     stop, always high
	// Device changes data while the PS/2 clock is high
	// Host samples on the falling PS/2 clock edge

endpackage

`default_nettype wire

// ==== src/keypad_pkg.sv ====
`default_nettype none

package keypad_pkg;

	import ps2_pkg::*;

	// Seven segment lines, active low, bit 0 is segment a
	localparam int SEG_BITS = 7;

	typedef logic [SEG_BITS-1:0] seg_t;

	// Direction number handed to the motion controller
	typedef logic [7:0] direction_t;

	localparam direction_t DIR_NONE    = 8'd0;
	localparam direction_t DIR_FORWARD = 8'd1;
	localparam direction_t DIR_LEFT    = 8'd2;
	localparam direction_t DIR_RIGHT   = 8'd3;

	// Set 2 make codes of the direction keys
	localparam scan_code_t KEY_FORWARD = 8'h2B;
	localparam scan_code_t KEY_LEFT    = 8'h4B;
	localparam scan_code_t KEY_RIGHT   = 8'h2D;

	// Segment pattern of one hex nibble
	function automatic seg_t hex_to_seg(input logic [3:0] nibble);
		seg_t seg;
		case (nibble)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'hA: seg = 7'b0001000;
			4'hB: seg = 7'b0000011;
			4'hC: seg = 7'b1000110;
			4'hD: seg = 7'b0100001;
			4'hE: seg = 7'b0000110;
			default: seg = 7'b0001110;
		endcase
		return seg;
	endfunction

	// Direction keys map to 1..3, every other code to none
	function automatic direction_t code_to_direction(input scan_code_t code);
		direction_t dir;
		case (code)
			KEY_FORWARD: dir = DIR_FORWARD;
			KEY_LEFT:    dir = DIR_LEFT;
			KEY_RIGHT:   dir = DIR_RIGHT;
			default:     dir = DIR_NONE;
		endcase
		return dir;
	endfunction

endpackage

`default_nettype wire

// ==== src/ps2_receiver.sv ====
`default_nettype none

module ps2_receiver
	import ps2_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic       ps2_clk,
	input  wire logic       ps2_data,
	input  wire logic       rx_ready,
	output logic            rx_valid,
	output scan_code_t      rx_code,
	output logic            rx_drop
);

	localparam int BIT_COUNT_BITS = $clog2(FRAME_DATA_BITS);
	localparam logic [BIT_COUNT_BITS-1:0] LAST_BIT = BIT_COUNT_BITS'(FRAME_DATA_BITS - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DATA,
		ST_PARITY,
		ST_STOP
	} state_t;

	state_t state;
	state_t next_state;

	// Two-flop synchronizers plus previous clock level
	logic ps2_clk_meta;
	logic ps2_clk_sync;
	logic ps2_clk_prev;
	logic ps2_data_meta;
	logic ps2_data_sync;
	logic clk_fall;

	logic [BIT_COUNT_BITS-1:0] bit_count;
	scan_code_t shift_reg;
	logic parity_ok;
	logic frame_good;
	logic out_free;

	// Lines idle high, so reset to the idle level
	// Avoids a false edge right after reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ps2_clk_meta  <= LINE_IDLE;
			ps2_clk_sync  <= LINE_IDLE;
			ps2_clk_prev  <= LINE_IDLE;
			ps2_data_meta <= LINE_IDLE;
			ps2_data_sync <= LINE_IDLE;
		end
		else
		begin
			ps2_clk_meta  <= ps2_clk;
			ps2_clk_sync  <= ps2_clk_meta;
			ps2_clk_prev  <= ps2_clk_sync;
			ps2_data_meta <= ps2_data;
			ps2_data_sync <= ps2_data_meta;
		end
	end

	// Falling PS/2 clock, data is stable here
	assign clk_fall = ps2_clk_prev & ~ps2_clk_sync;

	// Receive FSM
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			// Start bit must be low, otherwise stay idle
			ST_IDLE:
				if (clk_fall && (ps2_data_sync == 1'b0))
					next_state = ST_DATA;
			ST_DATA:
				if (clk_fall && (bit_count == LAST_BIT))
					next_state = ST_PARITY;
			ST_PARITY:
				if (clk_fall)
					next_state = ST_STOP;
			ST_STOP:
				if (clk_fall)
					next_state = ST_IDLE;
			default:
				next_state = ST_IDLE;
		endcase
	end

	// Data bit index, cleared outside the data phase
	always_ff @(posedge clk)
	begin
		if (reset)
			bit_count <= '0;
		else if ((state == ST_DATA) && clk_fall)
			bit_count <= bit_count + 1'b1;
		else if (state != ST_DATA)
			bit_count <= '0;
	end

	// LSB arrives first, shift in from the top
	always_ff @(posedge clk)
	begin
		if ((state == ST_DATA) && clk_fall)
			shift_reg <= {ps2_data_sync, shift_reg[SCAN_CODE_BITS-1:1]};
	end

	// Odd parity, data plus parity bit hold an odd number of ones
	always_ff @(posedge clk)
	begin
		if ((state == ST_PARITY) && clk_fall)
			parity_ok <= ^{shift_reg, ps2_data_sync};
	end

	// Stop bit high and parity good
	assign frame_good = (state == ST_STOP) && clk_fall && ps2_data_sync && parity_ok;

	// Output register is free when empty or handing off this cycle
	assign out_free = !rx_valid || rx_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rx_valid <= 1'b0;
			rx_drop  <= 1'b0;
		end
		else
		begin
			rx_drop <= 1'b0;
			if (rx_valid && rx_ready)
				rx_valid <= 1'b0;
			// Line cannot stall, so a blocked code is lost
			if (frame_good)
			begin
				if (out_free)
					rx_valid <= 1'b1;
				else
					rx_drop <= 1'b1;
			end
		end
	end

	// Code held steady until the FIFO takes it
	always_ff @(posedge clk)
	begin
		if (frame_good && out_free)
			rx_code <= shift_reg;
	end

endmodule

`default_nettype wire

// ==== src/code_fifo.sv ====
`default_nettype none

module code_fifo
	import ps2_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        in_valid,
	input  wire scan_code_t  in_code,
	input  wire logic        in_drop,
	input  wire logic        out_ready,
	output logic             in_ready,
	output logic             out_valid,
	output scan_code_t       out_code,
	output logic             overflow
);

	// Depth is a power of two, pointers wrap on their own
	localparam int ADDR_BITS = $clog2(FIFO_DEPTH);
	localparam logic [ADDR_BITS:0] FULL_COUNT = (ADDR_BITS + 1)'(FIFO_DEPTH);

	scan_code_t mem [FIFO_DEPTH];

	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	logic [ADDR_BITS:0] count;
	logic wr_en;
	logic rd_en;

	assign in_ready  = (count != FULL_COUNT);
	assign out_valid = (count != '0);

	// Oldest entry, shown ahead of the read
	assign out_code = mem[rd_ptr];

	assign wr_en = in_valid && in_ready;
	assign rd_en = out_valid && out_ready;

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= in_code;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous write and read leaves the count alone
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Sticky, any lost code since reset
	always_ff @(posedge clk)
	begin
		if (reset)
			overflow <= 1'b0;
		else if (in_drop)
			overflow <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== src/key_decoder.sv ====
`default_nettype none

module key_decoder
	import ps2_pkg::*;
	import keypad_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        in_valid,
	input  wire scan_code_t  in_code,
	input  wire logic        hold,
	output logic             in_ready,
	output scan_code_t       last_code,
	output seg_t             hex_lo,
	output seg_t             hex_hi,
	output direction_t       direction
);

	logic take;
	seg_t next_lo;
	seg_t next_hi;
	direction_t next_direction;

	// Downstream busy while hold is high
	assign in_ready = ~hold;

	assign take = in_valid && in_ready;

	// Display and direction of the incoming code
	assign next_lo = hex_to_seg(in_code[3:0]);
	assign next_hi = hex_to_seg(in_code[7:4]);

	// F0 and E0 prefixes map to none like any other code
	assign next_direction = code_to_direction(in_code);

	// Last accepted code
	always_ff @(posedge clk)
	begin
		if (reset)
			last_code <= '0;
		else if (take)
			last_code <= in_code;
	end

	// Two digits, low nibble on the right
	// Show 00 out of reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hex_lo <= hex_to_seg(4'h0);
			hex_hi <= hex_to_seg(4'h0);
		end
		else if (take)
		begin
			hex_lo <= next_lo;
			hex_hi <= next_hi;
		end
	end

	// Command for the motion side
	always_ff @(posedge clk)
	begin
		if (reset)
			direction <= DIR_NONE;
		else if (take)
			direction <= next_direction;
	end

endmodule

`default_nettype wire

// ==== src/ps2_keypad.sv ====
`default_nettype none

module ps2_keypad
	import ps2_pkg::*;
	import keypad_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  wire logic   clk,
	input  wire logic   reset,
	input  wire logic   ps2_clk,
	input  wire logic   ps2_data,
	input  wire logic   hold,
	output scan_code_t  last_code,
	output seg_t        hex_lo,
	output seg_t        hex_hi,
	output direction_t  direction,
	output logic        overflow
);

	// Receiver to FIFO
	logic rx_valid;
	logic rx_ready;
	logic rx_drop;
	scan_code_t rx_code;

	// FIFO to decoder
	logic fifo_valid;
	logic fifo_ready;
	scan_code_t fifo_code;

	// Frames in from the keyboard
	ps2_receiver ps2_receiver_inst (
		.clk      (clk),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.rx_ready (rx_ready),
		.rx_valid (rx_valid),
		.rx_code  (rx_code),
		.rx_drop  (rx_drop)
	);

	// Buffers codes while the decoder is held
	code_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) code_fifo_inst (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (rx_valid),
		.in_code   (rx_code),
		.in_drop   (rx_drop),
		.out_ready (fifo_ready),
		.in_ready  (rx_ready),
		.out_valid (fifo_valid),
		.out_code  (fifo_code),
		.overflow  (overflow)
	);

	// Display and direction
	key_decoder key_decoder_inst (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (fifo_valid),
		.in_code   (fifo_code),
		.hold      (hold),
		.in_ready  (fifo_ready),
		.last_code (last_code),
		.hex_lo    (hex_lo),
		.hex_hi    (hex_hi),
		.direction (direction)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_ps2_keypad.sv ====
`default_nettype none

module tb_ps2_keypad
	import ps2_pkg::*;
	import keypad_pkg::*;
();

	localparam int FIFO_DEPTH = 4;
	localparam int PS2_HALF = 8;
	localparam int SETTLE_CYCLES = 40;
	localparam int FRAME_BITS = FRAME_DATA_BITS + 3;
	// Columns per vector line
	localparam int VEC_FIELDS = 5;
	localparam int MAX_TESTS = 32;
	localparam logic [15:0] SENTINEL = 16'hFFFF;

	logic clk = 1'b0;
	logic reset;
	logic ps2_clk;
	logic ps2_data;
	logic hold;

	scan_code_t last_code;
	seg_t hex_lo;
	seg_t hex_hi;
	direction_t direction;
	logic overflow;

	logic [15:0] vectors [MAX_TESTS * VEC_FIELDS];
	int num_tests;
	int cycle_count = 0;
	int timeout_limit = 0;
	int hold_until = 0;

	// Reference model of the expected display state
	scan_code_t exp_code;
	logic exp_overflow;
	scan_code_t pending [$];

	string test_name;
	int test_errors;
	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	ps2_keypad #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) ps2_keypad_inst (
		.clk       (clk),
		.reset     (reset),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.hold      (hold),
		.last_code (last_code),
		.hex_lo    (hex_lo),
		.hex_hi    (hex_hi),
		.direction (direction),
		.overflow  (overflow)
	);

	always #2 clk = ~clk;

	// Cycle count and run limit
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if ((timeout_limit != 0) && (cycle_count >= timeout_limit))
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", timeout_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Steps on falling edges, drops hold once its time is up
	task automatic wait_cycles(input int n);
		repeat (n)
		begin
			@(negedge clk);
			if (hold && (cycle_count >= hold_until))
				hold = 1'b0;
		end
	endtask

	// One device-to-host frame, data set while the PS/2 clock is high
	task automatic send_frame(input scan_code_t code, input logic bad_parity,
		input logic bad_stop);
		logic [FRAME_BITS-1:0] frame;
		int i;
		frame[0] = 1'b0;
		frame[FRAME_DATA_BITS:1] = code;
		// Odd parity, flipped on request
		frame[FRAME_DATA_BITS+1] = ~(^code) ^ bad_parity;
		frame[FRAME_BITS-1] = ~bad_stop;
		for (i = 0; i < FRAME_BITS; i++)
		begin
			ps2_data = frame[i];
			wait_cycles(PS2_HALF);
			ps2_clk = 1'b0;
			wait_cycles(PS2_HALF);
			ps2_clk = 1'b1;
		end
		ps2_data = LINE_IDLE;
		// Idle gap between frames
		wait_cycles(2 * PS2_HALF);
	endtask

	// Decoder takes every buffered code once hold is low
	task automatic drain_model();
		if (pending.size() != 0)
			exp_code = pending[$];
		pending.delete();
	endtask

	// Receiver register plus FIFO give FIFO_DEPTH + 1 slots
	task automatic model_frame(input scan_code_t code, input logic good);
		if (!hold)
			drain_model();
		if (good)
		begin
			if (!hold)
				exp_code = code;
			else if (pending.size() < FIFO_DEPTH + 1)
				pending.push_back(code);
			else
				exp_overflow = 1'b1;
		end
	endtask

	task automatic compare_code(input string field, input scan_code_t expected,
		input scan_code_t actual);
		if (actual !== expected)
		begin
			$display("** Error %s %s: expected %h, actual %h", test_name, field, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_seg(input string field, input seg_t expected, input seg_t actual);
		if (actual !== expected)
		begin
			$display("** Error %s %s: expected %b, actual %b", test_name, field, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_direction(input string field, input direction_t expected,
		input direction_t actual);
		if (actual !== expected)
		begin
			$display("** Error %s %s: expected %0d, actual %0d", test_name, field, expected,
				actual);
			test_errors++;
		end
	endtask

	task automatic compare_flag(input string field, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("** Error %s %s: expected %b, actual %b", test_name, field, expected, actual);
			test_errors++;
		end
	endtask

	// Digits and direction follow the expected code
	task automatic check_outputs();
		compare_code("last_code", exp_code, last_code);
		compare_seg("hex_lo", hex_to_seg(exp_code[3:0]), hex_lo);
		compare_seg("hex_hi", hex_to_seg(exp_code[7:4]), hex_hi);
		compare_direction("direction", code_to_direction(exp_code), direction);
		compare_flag("overflow", exp_overflow, overflow);
	endtask

	task automatic report_test();
		if (test_errors == 0)
		begin
			$display("%s ok", test_name);
			tests_passed++;
		end
		else
		begin
			$display("%s: %0d mismatches", test_name, test_errors);
			tests_failed++;
		end
		error_count += test_errors;
	endtask

	// One vector line, frame then settle then check
	task automatic run_test(input int index);
		int base;
		int hold_cycles;
		scan_code_t code;
		logic bad_parity;
		logic bad_stop;
		base = index * VEC_FIELDS;
		code = vectors[base + 1][7:0];
		bad_parity = vectors[base + 2][0];
		bad_stop = vectors[base + 3][0];
		hold_cycles = int'(vectors[base + 4]);
		test_name = $sformatf("test %0d", int'(vectors[base]));
		test_errors = 0;
		if (hold_cycles > 0)
		begin
			hold = 1'b1;
			hold_until = cycle_count + hold_cycles;
		end
		send_frame(code, bad_parity, bad_stop);
		model_frame(code, !(bad_parity || bad_stop));
		wait_cycles(SETTLE_CYCLES);
		if (!hold)
			drain_model();
		check_outputs();
		report_test();
	endtask

	initial
	begin
		reset = 1'b1;
		ps2_clk = LINE_IDLE;
		ps2_data = LINE_IDLE;
		hold = 1'b0;
		exp_code = '0;
		exp_overflow = 1'b0;

		// Unused entries keep the end marker
		for (int i = 0; i < MAX_TESTS * VEC_FIELDS; i++)
			vectors[i] = SENTINEL;
		$readmemh("testbench/ps2_keypad_vectors.txt", vectors);
		num_tests = 0;
		while ((num_tests < MAX_TESTS) && (vectors[num_tests * VEC_FIELDS] !== SENTINEL))
			num_tests++;
		timeout_limit = num_tests * 300 + 500;

		wait_cycles(10);
		reset = 1'b0;
		wait_cycles(2);

		// Outputs straight out of reset
		test_name = "reset";
		test_errors = 0;
		check_outputs();
		report_test();

		if (num_tests == 0)
			$display("No test vectors were loaded from testbench/ps2_keypad_vectors.txt");
		for (int i = 0; i < num_tests; i++)
			run_test(i);

		$display("Tests: %0d run, %0d passed, %0d failed, %0d mismatches",
			tests_passed + tests_failed, tests_passed, tests_failed, error_count);
		if ((tests_failed == 0) && (num_tests > 0))
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ps2_keypad.f ====
src/ps2_pkg.sv
src/keypad_pkg.sv
src/ps2_receiver.sv
src/code_fifo.sv
src/key_decoder.sv
src/ps2_keypad.sv
testbench/tb_ps2_keypad.sv

// ==== Makefile ====
# Verilator build and run of the PS/2 keypad testbench

TOP = tb_ps2_keypad

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f ps2_keypad.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/ps2_keypad_vectors.txt ====
// test (hex), scan code, parity error, stop error, hold cycles (hex)
// hold above zero raises hold before the frame for that many cycles
01 2b 0 0 0
02 4b 0 0 0
03 2d 0 0 0
04 1c 0 0 0
05 f0 0 0 0
06 2b 1 0 0
07 4b 0 1 0
08 2d 0 0 31c
09 4b 0 0 0
0a 2b 0 0 0
0b 1c 1 0 0
0c 11 0 0 5d4
0d 22 0 0 0
0e 33 0 0 0
0f 44 0 0 0
10 55 0 0 0
11 66 0 0 0
12 77 0 1 0
13 e0 0 0 0
14 4b 0 0 0
